//--- Bender.yml
package:
  name: if_stage

sources:
  - hdl/if_pkg.sv
  - hdl/pc_gen.sv
  - hdl/redirect_latch.sv
  - hdl/resp_timer.sv
  - hdl/fetch_fsm.sv
  - hdl/fetch_buffer.sv
  - hdl/if_stage.sv
  - target: test
    files:
      - tb/imem_model.sv
      - tb/tb_if_stage.sv

//--- hdl/fetch_buffer.sv
`default_nettype none

module fetch_buffer (
	input  wire                clk,
	input  wire                reset,
	input  wire                buf_load,
	input  wire                flush,
	input  wire                if_pkg::bus_data_t mem_r_data,
	input  wire                if_pkg::addr_t mem_r_addr,
	input  wire                out_ready,
	output logic               out_valid,
	output if_pkg::fetch_pkt_t out_pkt,
	output logic               buf_full
);
	import if_pkg::*;

	insn_t      word;
	fetch_pkt_t pkt;

	// bit 2 picks the half of the doubleword
	assign word = mem_r_addr[2] ? mem_r_data[63:32] : mem_r_data[31:0];

	always_comb begin
		pkt.pc   = mem_r_addr;
		pkt.insn = word;
		pkt.snpc = mem_r_addr + 64'd4;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (flush) begin
			out_valid <= 1'b0;
		end else if (buf_load) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0; // decode took it
		end
	end

	always_ff @(posedge clk) begin
		if (buf_load) begin
			out_pkt <= pkt;
		end
	end

	assign buf_full = out_valid;

endmodule

`default_nettype wire

//--- hdl/fetch_fsm.sv
`default_nettype none

module fetch_fsm (
	input  wire  clk,
	input  wire  reset,
	input  wire  mem_ar_ready,
	input  wire  mem_r_valid,
	input  wire  if_pkg::redirect_t redirect,
	input  wire  flush,
	input  wire  buf_full,
	input  wire  out_ready,
	input  wire  timed_out,
	output logic mem_req,
	output logic pc_advance,
	output logic redirect_take,
	output logic buf_load,
	output logic timer_start,
	output logic timer_stop,
	output logic fetch_fault
);
	import if_pkg::*;

	fetch_state_t state;
	fetch_state_t state_next;
	logic         room;
	logic         resp;

	assign room = !buf_full || out_ready; // buffer empty or draining now
	assign resp = (state == S_WAIT) && mem_r_valid;

	always_comb begin
		state_next    = state;
		mem_req       = 1'b0;
		pc_advance    = 1'b0;
		redirect_take = 1'b0;
		buf_load      = 1'b0;
		case (state)
			S_IDLE: begin
				state_next = S_REQ;
			end
			S_REQ: begin
				if (redirect.pending) begin
					pc_advance    = 1'b1; // load target, request next cycle
					redirect_take = 1'b1;
				end else begin
					mem_req = room;
					if (room && mem_ar_ready) begin
						state_next = S_WAIT;
					end
				end
			end
			S_WAIT: begin
				if (mem_r_valid) begin
					state_next = S_REQ;
					// a strobe right now has no target latched yet, S_REQ takes it
					if (!flush && redirect.pending) begin
						pc_advance    = 1'b1; // read in flight belongs to a dead path
						redirect_take = 1'b1;
					end else if (!flush) begin
						buf_load   = 1'b1;
						pc_advance = 1'b1;
					end
				end else if (timed_out) begin
					state_next = S_FAULT;
				end
			end
			default: begin
				state_next = S_FAULT; // only reset leaves
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			state <= state_next;
		end
	end

	assign timer_start = mem_req && mem_ar_ready;
	assign timer_stop  = resp;
	assign fetch_fault = (state == S_FAULT);

endmodule

`default_nettype wire

//--- hdl/if_pkg.sv
`default_nettype none

package if_pkg;

	typedef logic [63:0] addr_t;     // byte address, pc and redirect targets
	typedef logic [31:0] insn_t;
	typedef logic [63:0] bus_data_t; // one doubleword per read

	// what decode receives
	typedef struct packed {
		addr_t pc;
		insn_t insn;
		addr_t snpc; // sequential next pc
	} fetch_pkt_t;

	typedef struct packed {
		logic  pending;
		addr_t target;
	} redirect_t;

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,
		S_WAIT,
		S_FAULT
	} fetch_state_t;

endpackage

`default_nettype wire

//--- hdl/if_stage.sv
`default_nettype none

module if_stage #(
	parameter if_pkg::addr_t RESET_PC       = 64'h8000_0000,
	parameter int unsigned   TIMEOUT_CYCLES = 32
) (
	input  wire                clk,
	input  wire                reset,
	// instruction bus
	output logic               mem_req,
	output if_pkg::addr_t      mem_addr,
	input  wire                mem_ar_ready,
	input  wire                mem_r_valid,
	input  wire                if_pkg::bus_data_t mem_r_data,
	input  wire                if_pkg::addr_t mem_r_addr,
	// redirects from decode, execute and memory
	input  wire                jal_redirect,
	input  wire                if_pkg::addr_t jal_target,
	input  wire                jalr_redirect,
	input  wire                if_pkg::addr_t jalr_target,
	input  wire                br_redirect,
	input  wire                if_pkg::addr_t br_target,
	// to decode
	output logic               out_valid,
	output if_pkg::fetch_pkt_t out_pkt,
	input  wire                out_ready,
	output logic               fetch_fault
);
	import if_pkg::*;

	redirect_t redirect;
	logic      flush;
	logic      redirect_take;
	logic      pc_advance;
	logic      buf_load;
	logic      buf_full;
	logic      timer_start;
	logic      timer_stop;
	logic      timed_out;

	pc_gen #(.RESET_PC(RESET_PC)) u_pc_gen (
		.clk        (clk),
		.reset      (reset),
		.pc_advance (pc_advance),
		.redirect   (redirect),
		.pc         (mem_addr) // fetch pc goes straight to the bus
	);

	redirect_latch u_redirect_latch (
		.clk           (clk),
		.reset         (reset),
		.jal_redirect  (jal_redirect),
		.jalr_redirect (jalr_redirect),
		.br_redirect   (br_redirect),
		.jal_target    (jal_target),
		.jalr_target   (jalr_target),
		.br_target     (br_target),
		.redirect_take (redirect_take),
		.redirect      (redirect),
		.flush         (flush)
	);

	resp_timer #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_resp_timer (
		.clk         (clk),
		.reset       (reset),
		.timer_start (timer_start),
		.timer_stop  (timer_stop),
		.timed_out   (timed_out)
	);

	fetch_fsm u_fetch_fsm (
		.clk           (clk),
		.reset         (reset),
		.mem_ar_ready  (mem_ar_ready),
		.mem_r_valid   (mem_r_valid),
		.redirect      (redirect),
		.flush         (flush),
		.buf_full      (buf_full),
		.out_ready     (out_ready),
		.timed_out     (timed_out),
		.mem_req       (mem_req),
		.pc_advance    (pc_advance),
		.redirect_take (redirect_take),
		.buf_load      (buf_load),
		.timer_start   (timer_start),
		.timer_stop    (timer_stop),
		.fetch_fault   (fetch_fault)
	);

	fetch_buffer u_fetch_buffer (
		.clk        (clk),
		.reset      (reset),
		.buf_load   (buf_load),
		.flush      (flush),
		.mem_r_data (mem_r_data),
		.mem_r_addr (mem_r_addr),
		.out_ready  (out_ready),
		.out_valid  (out_valid),
		.out_pkt    (out_pkt),
		.buf_full   (buf_full)
	);

endmodule

`default_nettype wire

//--- hdl/pc_gen.sv
`default_nettype none

module pc_gen #(
	parameter if_pkg::addr_t RESET_PC = 64'h8000_0000
) (
	input  wire               clk,
	input  wire               reset,
	input  wire               pc_advance,
	input  wire               if_pkg::redirect_t redirect,
	output if_pkg::addr_t     pc
);
	import if_pkg::*;

	addr_t pc_seq;

	assign pc_seq = pc + 64'd4;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= RESET_PC;
		end else if (pc_advance) begin
			if (redirect.pending) begin
				pc <= redirect.target; // redirect beats the sequential step
			end else begin
				pc <= pc_seq;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/redirect_latch.sv
`default_nettype none

module redirect_latch (
	input  wire               clk,
	input  wire               reset,
	input  wire               jal_redirect,
	input  wire               jalr_redirect,
	input  wire               br_redirect,
	input  wire               if_pkg::addr_t jal_target,
	input  wire               if_pkg::addr_t jalr_target,
	input  wire               if_pkg::addr_t br_target,
	input  wire               redirect_take,
	output if_pkg::redirect_t redirect,
	output logic              flush
);
	import if_pkg::*;

	addr_t sel_target;
	addr_t target_q;
	logic  pending_q;

	assign flush = jal_redirect | jalr_redirect | br_redirect;

	// memory stage is oldest in program order, then execute, then decode
	always_comb begin
		if (br_redirect) begin
			sel_target = br_target;
		end else if (jalr_redirect) begin
			sel_target = jalr_target;
		end else begin
			sel_target = jal_target;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pending_q <= 1'b0;
		end else if (flush) begin
			pending_q <= 1'b1; // new strobe survives a take in the same cycle
		end else if (redirect_take) begin
			pending_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (flush) begin
			target_q <= sel_target;
		end
	end

	assign redirect = '{pending: pending_q, target: target_q};

endmodule

`default_nettype wire

//--- hdl/resp_timer.sv
`default_nettype none

module resp_timer #(
	parameter int unsigned TIMEOUT_CYCLES = 32
) (
	input  wire  clk,
	input  wire  reset,
	input  wire  timer_start,
	input  wire  timer_stop,
	output logic timed_out
);

	localparam int unsigned CNT_W = $clog2(TIMEOUT_CYCLES + 1);

	logic [CNT_W-1:0] count;
	logic             running;

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			count   <= '0;
		end else if (timer_start) begin
			running <= 1'b1;
			count   <= '0;
		end else if (timer_stop) begin
			running <= 1'b0;
		end else if (running && !timed_out) begin
			count <= count + 1'b1; // holds at the limit
		end
	end

	assign timed_out = running && (count == CNT_W'(TIMEOUT_CYCLES));

endmodule

`default_nettype wire

//--- src.f
hdl/if_pkg.sv
hdl/pc_gen.sv
hdl/redirect_latch.sv
hdl/resp_timer.sv
hdl/fetch_fsm.sv
hdl/fetch_buffer.sv
hdl/if_stage.sv
tb/imem_model.sv
tb/tb_if_stage.sv

//--- tb/imem_model.sv
`default_nettype none

module imem_model (
	input  wire               clk,
	input  wire               reset,
	input  wire               mute,     // withhold every response
	input  wire               req,
	input  wire               if_pkg::addr_t addr,
	output logic              ar_ready,
	output logic              r_valid,
	output if_pkg::bus_data_t r_data,
	output if_pkg::addr_t     r_addr
);
	timeunit 1ns;
	timeprecision 1ps;
	import if_pkg::*;

	logic [31:0] lfsr = 32'haa22;
	logic        rst_q = 1'b1;
	logic        mute_q = 1'b0;
	logic        taken = 1'b0; // read accepted at the last rising edge
	addr_t       taken_addr;
	logic        busy = 1'b0;  // response still owed
	addr_t       resp_addr;
	int          delay = 0;

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		int          i;
		val = '0;
		for (i = 0; i < n; i++) begin
			val  = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return val;
	endfunction

	// each half holds the word of its own address
	function automatic bus_data_t dword_at(input addr_t a);
		return {{a[31:3], 3'b100} ^ 32'h5a5a_0000, {a[31:3], 3'b000} ^ 32'h5a5a_0000};
	endfunction

	initial begin
		ar_ready = 1'b0;
		r_valid  = 1'b0;
		r_data   = '0;
		r_addr   = '0;
	end

	always @(posedge clk) begin
		rst_q      <= reset;
		mute_q     <= mute;
		taken      <= req && ar_ready;
		taken_addr <= addr;
	end

	always @(negedge clk) begin
		r_valid <= 1'b0;
		if (rst_q) begin
			ar_ready <= 1'b0;
			busy = 1'b0;
			delay = 0;
		end else begin
			if (taken) begin
				ar_ready <= 1'b0;
				busy = 1'b1;
				resp_addr = taken_addr;
				delay = take_bits(3) % 6; // 1 to 6 cycles of latency
			end
			if (busy) begin
				if (!mute_q && delay == 0) begin
					r_valid <= 1'b1;
					r_addr  <= resp_addr;
					r_data  <= dword_at(resp_addr);
					busy = 1'b0;
					delay = take_bits(2); // 0 to 3 cycles before ar_ready
				end else if (delay != 0) begin
					delay--;
				end
			end else if (delay == 0) begin
				ar_ready <= 1'b1;
			end else begin
				delay--;
			end
		end
	end

endmodule

`default_nettype wire

//--- tb/tb_if_stage.sv
`default_nettype none

module tb_if_stage;
	timeunit 1ns;
	timeprecision 1ps;
	import if_pkg::*;

	localparam addr_t RESET_PC       = 64'h8000_0000;
	localparam int    TIMEOUT_CYCLES = 32;
	localparam int    NUM_PHASES     = 6;
	localparam int    PHASE_CYCLES   = 400;

	logic       clk = 1'b0;
	logic       reset;
	logic       mem_req;
	addr_t      mem_addr;
	logic       mem_ar_ready;
	logic       mem_r_valid;
	bus_data_t  mem_r_data;
	addr_t      mem_r_addr;
	logic       jal_redirect;
	logic       jalr_redirect;
	logic       br_redirect;
	addr_t      jal_target;
	addr_t      jalr_target;
	addr_t      br_target;
	logic       out_valid;
	fetch_pkt_t out_pkt;
	logic       out_ready;
	logic       fetch_fault;
	logic       mute;

	logic [31:0] lfsr = 32'haa22;
	int          xfer_count = 0;
	addr_t       exp_pc = RESET_PC;
	logic        reset_q = 1'b0;
	logic        first_req = 1'b1;
	logic        fault_seen = 1'b0;
	logic        prev_hold = 1'b0;  // packet stalled last cycle
	logic        prev_flush = 1'b0;
	fetch_pkt_t  prev_pkt;
	logic        dead_valid = 1'b0;
	addr_t       dead_pc;

	if_stage #(
		.RESET_PC       (RESET_PC),
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES)
	) u_if_stage (
		.clk           (clk),
		.reset         (reset),
		.mem_req       (mem_req),
		.mem_addr      (mem_addr),
		.mem_ar_ready  (mem_ar_ready),
		.mem_r_valid   (mem_r_valid),
		.mem_r_data    (mem_r_data),
		.mem_r_addr    (mem_r_addr),
		.jal_redirect  (jal_redirect),
		.jal_target    (jal_target),
		.jalr_redirect (jalr_redirect),
		.jalr_target   (jalr_target),
		.br_redirect   (br_redirect),
		.br_target     (br_target),
		.out_valid     (out_valid),
		.out_pkt       (out_pkt),
		.out_ready     (out_ready),
		.fetch_fault   (fetch_fault)
	);

	imem_model u_imem (
		.clk      (clk),
		.reset    (reset),
		.mute     (mute),
		.req      (mem_req),
		.addr     (mem_addr),
		.ar_ready (mem_ar_ready),
		.r_valid  (mem_r_valid),
		.r_data   (mem_r_data),
		.r_addr   (mem_r_addr)
	);

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		int          i;
		val = '0;
		for (i = 0; i < n; i++) begin
			val  = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return val;
	endfunction

	function automatic insn_t expected_insn(input addr_t pc);
		return pc[31:0] ^ 32'h5a5a_0000;
	endfunction

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic wait_transfers(input int n);
		int goal;
		goal = xfer_count + n;
		while (xfer_count < goal) begin
			@(negedge clk);
		end
	endtask

	// call at a falling edge, strobes last one cycle
	task automatic fire_redirect(input logic [2:0] sel, input addr_t base);
		{br_redirect, jalr_redirect, jal_redirect} = sel;
		jal_target  = base + 64'h0000_0004;
		jalr_target = base + 64'h0001_0000;
		br_target   = base + 64'h0002_000c;
		@(negedge clk);
		{br_redirect, jalr_redirect, jal_redirect} = 3'b000;
	endtask

	task automatic catch_accept(output addr_t pc);
		@(posedge clk);
		while (!(mem_req && mem_ar_ready)) begin
			@(posedge clk);
		end
		pc = mem_addr;
	endtask

	initial begin
		forever #10 clk = ~clk;
	end

	initial begin
		repeat (NUM_PHASES * PHASE_CYCLES) @(posedge clk);
		abort_run("watchdog expired before the tests finished");
	end

	always @(posedge clk) begin : monitor
		addr_t next_pc;
		next_pc = exp_pc;
		if (reset_q) begin
			assert (!mem_req && !out_valid && !fetch_fault)
				else abort_run($sformatf("ERR reset mem_req %h out_valid %h fetch_fault %h",
					mem_req, out_valid, fetch_fault));
		end
		if (reset) begin
			next_pc = RESET_PC;
			first_req  <= 1'b1;
			fault_seen <= 1'b0;
			prev_hold  <= 1'b0;
			prev_flush <= 1'b0;
		end else begin
			if (first_req && mem_req) begin
				assert (mem_addr == RESET_PC)
					else abort_run($sformatf("ERR mem_addr %h expected %h", mem_addr, RESET_PC));
				first_req <= 1'b0;
			end
			if (out_valid && out_ready) begin
				assert (!(dead_valid && out_pkt.pc == dead_pc))
					else abort_run("a killed fetch was still delivered to decode");
				assert (out_pkt.pc == exp_pc)
					else abort_run($sformatf("ERR out_pkt.pc %h expected %h", out_pkt.pc, exp_pc));
				assert (out_pkt.insn == expected_insn(exp_pc))
					else abort_run($sformatf("ERR out_pkt.insn %h expected %h",
						out_pkt.insn, expected_insn(exp_pc)));
				assert (out_pkt.snpc == exp_pc + 64'd4)
					else abort_run($sformatf("ERR out_pkt.snpc %h expected %h",
						out_pkt.snpc, exp_pc + 64'd4));
				xfer_count <= xfer_count + 1;
				next_pc = exp_pc + 64'd4;
			end
			if (br_redirect) begin
				next_pc = br_target; // memory stage wins
			end else if (jalr_redirect) begin
				next_pc = jalr_target;
			end else if (jal_redirect) begin
				next_pc = jal_target;
			end
			if (prev_hold) begin
				assert (out_valid && out_pkt == prev_pkt)
					else abort_run($sformatf("ERR out_pkt %h held %h out_valid %h",
						out_pkt, prev_pkt, out_valid));
			end
			if (prev_flush) begin
				assert (!out_valid)
					else abort_run($sformatf("ERR out_valid %h after flush", out_valid));
			end
			assert (!(mem_req && mem_ar_ready && out_valid && !out_ready))
				else abort_run("a read was accepted while decode stalled a full buffer");
			if (fault_seen) begin
				assert (fetch_fault) else abort_run("fetch_fault dropped before reset");
			end
			if (fetch_fault) begin
				assert (!mem_req) else abort_run($sformatf("ERR mem_req %h in fault", mem_req));
			end
			fault_seen <= fault_seen || fetch_fault;
			prev_flush <= jal_redirect || jalr_redirect || br_redirect;
			prev_hold  <= out_valid && !out_ready &&
				!(jal_redirect || jalr_redirect || br_redirect);
			prev_pkt   <= out_pkt;
		end
		exp_pc  <= next_pc;
		reset_q <= reset;
	end

	initial begin
		int    k;
		int    stall_left;
		addr_t victim;
		reset = 1'b1;
		mute = 1'b0;
		out_ready = 1'b0;
		{br_redirect, jalr_redirect, jal_redirect} = 3'b000;
		jal_target = '0;
		jalr_target = '0;
		br_target = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		out_ready = 1'b1;
		wait_transfers(24); // straight line code, both halves
		for (k = 1; k < 8; k++) begin
			wait_transfers(2);
			fire_redirect(k[2:0], 64'h8010_0000 + 64'(k) * 64'h100);
		end
		for (k = 0; k < 4; k++) begin
			wait_transfers(2);
			catch_accept(victim);
			@(negedge clk);
			dead_pc = victim; // response for this one must be dropped
			dead_valid = 1'b1;
			fire_redirect(k[0] ? 3'b100 : 3'b010, 64'h8020_0000 + 64'(k) * 64'h1000);
			wait_transfers(2);
			dead_valid = 1'b0;
		end
		stall_left = 0;
		k = xfer_count + 20;
		while (xfer_count < k) begin
			@(negedge clk);
			if (stall_left == 0) begin
				out_ready = take_bits(1) != 0;
				stall_left = int'(take_bits(3));
			end else begin
				stall_left--;
			end
		end
		out_ready = 1'b0; // flush a packet that decode holds off
		while (!out_valid) @(negedge clk);
		fire_redirect(3'b001, 64'h8030_0000);
		out_ready = 1'b1;
		wait_transfers(3);
		mute = 1'b1;
		while (!fetch_fault) @(negedge clk);
		repeat (20) @(negedge clk);
		reset = 1'b1;
		mute = 1'b0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		wait_transfers(4);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
